// ==== compile.f ====
src/pipe_ctrl_pkg.sv
src/pc_reg.sv
src/hazard_unit.sv
src/ctrl.sv
src/pipe_reg.sv
src/pipe_front_top.sv
tb/tb_pipe_front.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the front-end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_pipe_front \
    -o sim_pipe_front

sim_out=$(./obj_dir/sim_pipe_front)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// ==== src/ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ctrl: merges jump, stall and flush
// requests into stage controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ctrl
    import pipe_ctrl_pkg::*;
(
    // assertion sampling only
    input  logic            clk,

    // from execute
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_addr_i,
    input  logic            ex_stall_i,
    // atomic unit busy
    input  logic            atom_busy_i,

    // from interrupt controller
    input  logic            irq_flush_i,

    // from hazard unit
    input  logic            hdu_stall_i,

    // to pipeline registers
    output stage_ctrl_t     ctrl_o,

    // to pc_reg
    output logic            jump_o,
    output logic [XLEN-1:0] jump_addr_o
);

    // jump has to wait for the atomic op
    logic atom_hold;

    assign atom_hold = atom_busy_i & jump_i;

    // target passes straight through
    assign jump_addr_o = jump_addr_i;

    // redirect only once execute and atomic unit let go
    assign jump_o = jump_i & ~ex_stall_i & ~atom_hold;

    // a taken jump kills the dependent instruction anyway,
    // so the load-use stall is dropped then
    assign ctrl_o.hold_fetch = ex_stall_i | (hdu_stall_i & ~jump_i) | atom_hold;

    // redirect or interrupt empties front stages
    assign ctrl_o.flush = jump_o | irq_flush_i;

    // execute back-pressure freezes dispatch too
    assign ctrl_o.hold_dispatch = ex_stall_i;

    // front held but dispatch moving, insert empty slot
    assign ctrl_o.bubble_dispatch = ctrl_o.hold_fetch & ~ctrl_o.hold_dispatch;

    // redirect must not start under back-pressure
    a_no_jump_in_stall: assert property (
        @(posedge clk) $rose(jump_o) |-> !ex_stall_i
    ) else $error("ctrl: jump_o rose during ex_stall_i");

endmodule

// ==== src/hazard_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hazard_unit: load-use check between
// decode and dispatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hazard_unit
    import pipe_ctrl_pkg::*;
(
    // decode stage
    input  logic            id_valid_i,
    input  logic [XLEN-1:0] id_inst_i,

    // dispatch stage
    input  logic            disp_valid_i,
    input  disp_pkt_t       disp_pkt_i,

    // to ctrl
    output logic            stall_o
);

    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic             rd_nonzero;
    logic             rs1_hit;
    logic             rs2_hit;
    logic             load_in_disp;

    // source fields of the decode instruction
    // decoded for every format, a false match only costs a bubble
    assign rs1 = id_inst_i[RS1_LSB +: REG_W];
    assign rs2 = id_inst_i[RS2_LSB +: REG_W];

    // x0 never carries a dependency
    assign rd_nonzero = (disp_pkt_i.rd != '0);

    // compare against load destination
    assign rs1_hit = (disp_pkt_i.rd == rs1);
    assign rs2_hit = (disp_pkt_i.rd == rs2);

    // live load sitting in dispatch
    assign load_in_disp = disp_valid_i & disp_pkt_i.is_load;

    // both stages must hold real instructions
    always_comb begin
        stall_o = 1'b0;
        if (id_valid_i && load_in_disp && rd_nonzero) begin
            // data not back until after dispatch,
            // so the consumer waits one cycle
            if (rs1_hit || rs2_hit) begin
                stall_o = 1'b1;
            end
        end
    end

endmodule

// ==== src/pc_reg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter for the fetch stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pc_reg
    import pipe_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,

    // from ctrl
    input  logic            hold_i,
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_addr_i,

    // to fetch
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] pc_q;

    // priority: reset, redirect, hold, step
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (jump_i) begin
            // redirect from execute
            pc_q <= jump_addr_i;
        end else if (hold_i) begin
            // stall refetches the same address
            pc_q <= pc_q;
        end else begin
            pc_q <= pc_q + PC_STEP;
        end
    end

    assign pc_o = pc_q;

    // fetch address must stay word aligned,
    // which also catches a misaligned jump target one cycle later
    property p_pc_aligned;
        @(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00;
    endproperty

    a_pc_aligned: assert property (p_pc_aligned)
        else $error("pc_reg: misaligned pc %h", pc_q);

endmodule

// ==== src/pipe_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipe_ctrl_pkg: widths, opcodes and stage
// payload / control structs for the front end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pipe_ctrl_pkg;

    // machine word, instruction and address width
    localparam int XLEN = 32;

    // fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // sequential fetch step, one 32-bit instruction
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // register index width
    localparam int REG_W = 5;

    // opcode field
    localparam int OPC_W = 7;
    localparam logic [OPC_W-1:0] OP_LOAD = 7'b0000011;

    // instruction field positions (base encoding)
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    // fetch -> decode payload
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_pkt_t;

    // decode -> dispatch payload
    // only what the hazard check needs is decoded
    typedef struct packed {
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  inst;
        logic [REG_W-1:0] rd;
        logic             is_load;
    } disp_pkt_t;

    // per-stage controls from ctrl
    typedef struct packed {
        // pc and if/id keep contents
        logic hold_fetch;
        // if/id and id/disp lose their entries
        logic flush;
        // id/disp keeps contents
        logic hold_dispatch;
        // id/disp loads an empty slot
        logic bubble_dispatch;
    } stage_ctrl_t;

endpackage

// ==== src/pipe_front_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipe_front_top: pc, if/id, id/disp,
// hazard check and stage control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pipe_front_top
    import pipe_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,

    // instruction at pc_o
    input  logic [XLEN-1:0] inst_i,

    // from execute
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_addr_i,
    input  logic            ex_stall_i,

    // atomic unit and interrupt controller
    input  logic            atom_busy_i,
    input  logic            irq_flush_i,

    // fetch
    output logic [XLEN-1:0] pc_o,

    // decode stage
    output logic            id_valid_o,
    output logic [XLEN-1:0] id_inst_o,

    // dispatch stage
    output logic            disp_valid_o,
    output disp_pkt_t       disp_pkt_o,

    // control observation
    output stage_ctrl_t     ctrl_o,
    output logic            jump_o
);

    fetch_pkt_t      fetch_pkt;
    fetch_pkt_t      id_pkt;
    disp_pkt_t       dec_pkt;
    logic            hdu_stall;
    logic [XLEN-1:0] jump_addr;
    logic            disp_clear;

    // fetch payload
    assign fetch_pkt.pc   = pc_o;
    assign fetch_pkt.inst = inst_i;

    // minimal decode for the hazard check
    assign dec_pkt.pc      = id_pkt.pc;
    assign dec_pkt.inst    = id_pkt.inst;
    assign dec_pkt.rd      = id_pkt.inst[RD_LSB +: REG_W];
    assign dec_pkt.is_load = (id_pkt.inst[OPC_W-1:0] == OP_LOAD);

    assign id_inst_o = id_pkt.inst;

    // flush or bubble empties dispatch
    assign disp_clear = ctrl_o.flush | ctrl_o.bubble_dispatch;

    pc_reg u_pc_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .hold_i      (ctrl_o.hold_fetch),
        .jump_i      (jump_o),
        .jump_addr_i (jump_addr),
        .pc_o        (pc_o)
    );

    // fetch -> decode
    pipe_reg #(.payload_t(fetch_pkt_t)) if_id_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (ctrl_o.hold_fetch),
        .clear_i (ctrl_o.flush),
        .d_i     (fetch_pkt),
        .q_o     (id_pkt),
        .valid_o (id_valid_o)
    );

    // decode -> dispatch
    pipe_reg #(.payload_t(disp_pkt_t)) id_disp_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (ctrl_o.hold_dispatch),
        .clear_i (disp_clear),
        .d_i     (dec_pkt),
        .q_o     (disp_pkt_o),
        .valid_o (disp_valid_o)
    );

    hazard_unit u_hazard_unit (
        .id_valid_i   (id_valid_o),
        .id_inst_i    (id_pkt.inst),
        .disp_valid_i (disp_valid_o),
        .disp_pkt_i   (disp_pkt_o),
        .stall_o      (hdu_stall)
    );

    ctrl u_ctrl (
        .clk         (clk),
        .jump_i      (jump_i),
        .jump_addr_i (jump_addr_i),
        .ex_stall_i  (ex_stall_i),
        .atom_busy_i (atom_busy_i),
        .irq_flush_i (irq_flush_i),
        .hdu_stall_i (hdu_stall),
        .ctrl_o      (ctrl_o),
        .jump_o      (jump_o),
        .jump_addr_o (jump_addr)
    );

endmodule

// ==== src/pipe_reg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline stage register with hold and clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pipe_reg
    import pipe_ctrl_pkg::*;
#(
    parameter type payload_t = fetch_pkt_t
) (
    input  logic     clk,
    input  logic     reset_i,

    // stage controls
    input  logic     hold_i,
    input  logic     clear_i,

    input  payload_t d_i,
    output payload_t q_o,
    output logic     valid_o
);

    payload_t q_q;
    logic     valid_q;

    // valid bit: reset, clear, hold, load
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= 1'b1;
        end
    end

    // payload follows d_i unless held
    always_ff @(posedge clk) begin
        if (!hold_i) begin
            q_q <= d_i;
        end
    end

    assign q_o     = q_q;
    assign valid_o = valid_q;

    // held live entry keeps payload
    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        (valid_q && hold_i && !clear_i) |=> (valid_q && $stable(q_q))
    ) else $error("pipe_reg: held entry changed");

endmodule

// ==== tb/pipe_front_tests.txt ====
# inst jump jump_addr ex_stall atom_busy irq_flush | pc id_valid disp_valid
# hold_fetch flush hold_dispatch bubble_dispatch jump_o ; hex, one line per cycle
00000013 0 00000000 0 0 0 00000000 0 0 0 0 0 0 0
00100093 0 00000000 0 0 0 00000004 1 1 0 0 0 0 0
00200113 0 00000000 0 0 0 00000008 1 1 0 0 0 0 0
00000013 0 00000000 0 0 0 0000000c 1 1 0 0 0 0 0
00000013 1 00000100 0 0 0 00000010 1 1 0 1 0 0 1
00000013 0 00000000 0 0 0 00000100 0 0 0 0 0 0 0
00100093 0 00000000 0 0 0 00000104 1 1 0 0 0 0 0
0000a283 0 00000000 0 0 0 00000108 1 1 0 0 0 0 0
00028333 0 00000000 0 0 0 0000010c 1 1 0 0 0 0 0
00000013 0 00000000 0 0 0 00000110 1 1 1 0 0 1 0
00000013 0 00000000 0 0 0 00000110 1 0 0 0 0 0 0
00000013 0 00000000 0 0 0 00000114 1 1 0 0 0 0 0
00008003 0 00000000 0 0 0 00000118 1 1 0 0 0 0 0
00000333 0 00000000 0 0 0 0000011c 1 1 0 0 0 0 0
00000013 0 00000000 0 0 0 00000120 1 1 0 0 0 0 0
00000013 0 00000000 0 0 0 00000124 1 1 0 0 0 0 0
00100093 0 00000000 1 0 0 00000128 1 1 1 0 1 0 0
00100093 1 00000200 1 0 0 00000128 1 1 1 0 1 0 0
00100093 1 00000200 1 0 0 00000128 1 1 1 0 1 0 0
00100093 1 00000200 0 0 0 00000128 1 1 0 1 0 0 1
00000013 0 00000000 0 0 0 00000200 0 0 0 0 0 0 0
00000013 0 00000000 0 0 0 00000204 1 1 0 0 0 0 0
00200113 1 00000300 0 1 0 00000208 1 1 1 0 0 1 0
00200113 1 00000300 0 1 0 00000208 1 0 1 0 0 1 0
00200113 1 00000300 0 0 0 00000208 1 0 0 1 0 0 1
00000013 0 00000000 0 0 0 00000300 0 0 0 0 0 0 0
00000013 0 00000000 0 0 0 00000304 1 1 0 0 0 0 0
00100093 0 00000000 0 0 1 00000308 1 1 0 1 0 0 0
00000013 0 00000000 0 0 0 0000030c 0 0 0 0 0 0 0
00000013 0 00000000 0 0 0 00000310 1 1 0 0 0 0 0
0000a283 0 00000000 0 0 0 00000314 1 1 0 0 0 0 0
00028333 0 00000000 0 0 0 00000318 1 1 0 0 0 0 0
00000013 1 00000400 0 0 0 0000031c 1 1 0 1 0 0 1
00000013 0 00000000 0 0 0 00000400 0 0 0 0 0 0 0
00000013 0 00000000 0 0 0 00000404 1 1 0 0 0 0 0
00000013 0 00000000 1 0 1 00000408 1 1 1 1 1 0 0
00000013 0 00000000 0 0 0 00000408 0 0 0 0 0 0 0
00000013 0 00000000 0 0 0 0000040c 1 1 0 0 0 0 0

// ==== tb/tb_pipe_front.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector-driven testbench
// for the pipeline front end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_pipe_front
    import pipe_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD  = 40;
    localparam int    RESET_CYCLES = 10;
    localparam int    SLACK_CYCLES = 20;
    localparam string VEC_FILE    = "tb/pipe_front_tests.txt";

    // one cycle of stimulus plus expected outputs
    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic            jump;
        logic [XLEN-1:0] jump_addr;
        logic            ex_stall;
        logic            atom_busy;
        logic            irq_flush;
        logic [XLEN-1:0] pc;
        logic            id_valid;
        logic            disp_valid;
        stage_ctrl_t     ctrl;
        logic            jump_o;
    } vec_t;

    logic            clk;
    logic            reset_i;
    logic [XLEN-1:0] inst;
    logic            jump;
    logic [XLEN-1:0] jump_addr;
    logic            ex_stall;
    logic            atom_busy;
    logic            irq_flush;
    logic [XLEN-1:0] pc;
    logic            id_valid;
    logic [XLEN-1:0] id_inst;
    logic            disp_valid;
    disp_pkt_t       disp_pkt;
    stage_ctrl_t     ctrl;
    logic            jump_out;

    // expected stage contents, tracked from the vectors
    fetch_pkt_t      exp_id;
    disp_pkt_t       exp_disp;
    bit              exp_id_known;
    bit              exp_disp_known;

    vec_t vecs[$];
    int   vec_lines[$];
    int   errors;
    int   checks;
    bit   loaded;

    pipe_front_top DUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_i       (inst),
        .jump_i       (jump),
        .jump_addr_i  (jump_addr),
        .ex_stall_i   (ex_stall),
        .atom_busy_i  (atom_busy),
        .irq_flush_i  (irq_flush),
        .pc_o         (pc),
        .id_valid_o   (id_valid),
        .id_inst_o    (id_inst),
        .disp_valid_o (disp_valid),
        .disp_pkt_o   (disp_pkt),
        .ctrl_o       (ctrl),
        .jump_o       (jump_out)
    );

    // free-running clock
    always #(CLK_PERIOD / 2) clk = ~clk;

    // compare one output against its expected value
    task automatic check_value(input string name, input int line_no,
                               input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] line %0d: %s got %h expected %h", line_no, name, got, exp);
        end
    endtask

    // read every vector line up front
    // '#' lines and blank lines skipped
    task automatic load_vectors();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        vec_t        v;
        logic [31:0] f[14];
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the test vector file %s", VEC_FILE);
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (n != 14) begin
                errors++;
                $display("line %0d of %s is malformed and was skipped", line_no, VEC_FILE);
                continue;
            end
            v.inst                 = f[0];
            v.jump                 = f[1][0];
            v.jump_addr            = f[2];
            v.ex_stall             = f[3][0];
            v.atom_busy            = f[4][0];
            v.irq_flush            = f[5][0];
            v.pc                   = f[6];
            v.id_valid             = f[7][0];
            v.disp_valid           = f[8][0];
            v.ctrl.hold_fetch      = f[9][0];
            v.ctrl.flush           = f[10][0];
            v.ctrl.hold_dispatch   = f[11][0];
            v.ctrl.bubble_dispatch = f[12][0];
            v.jump_o               = f[13][0];
            vecs.push_back(v);
            vec_lines.push_back(line_no);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            errors++;
            $display("no test vectors found in %s", VEC_FILE);
        end
    endtask

    // stimulus for one cycle
    task automatic apply_inputs(input vec_t v);
        inst      = v.inst;
        jump      = v.jump;
        jump_addr = v.jump_addr;
        ex_stall  = v.ex_stall;
        atom_busy = v.atom_busy;
        irq_flush = v.irq_flush;
    endtask

    // all observed outputs of one cycle
    task automatic compare_outputs(input vec_t v, input int ln);
        check_value("pc_o", ln, pc, v.pc);
        check_value("id_valid_o", ln, 32'(id_valid), 32'(v.id_valid));
        check_value("disp_valid_o", ln, 32'(disp_valid), 32'(v.disp_valid));
        check_value("ctrl_o.hold_fetch", ln, 32'(ctrl.hold_fetch),
                    32'(v.ctrl.hold_fetch));
        check_value("ctrl_o.flush", ln, 32'(ctrl.flush), 32'(v.ctrl.flush));
        check_value("ctrl_o.hold_dispatch", ln, 32'(ctrl.hold_dispatch),
                    32'(v.ctrl.hold_dispatch));
        check_value("ctrl_o.bubble_dispatch", ln, 32'(ctrl.bubble_dispatch),
                    32'(v.ctrl.bubble_dispatch));
        check_value("jump_o", ln, 32'(jump_out), 32'(v.jump_o));
    endtask

    // stage payloads, only where the entry is live and known
    task automatic compare_payloads(input vec_t v, input int ln);
        if (v.id_valid && exp_id_known) begin
            check_value("id_inst_o", ln, id_inst, exp_id.inst);
        end
        if (v.disp_valid && exp_disp_known) begin
            check_value("disp_pkt_o.pc", ln, disp_pkt.pc, exp_disp.pc);
            check_value("disp_pkt_o.inst", ln, disp_pkt.inst, exp_disp.inst);
            check_value("disp_pkt_o.rd", ln, 32'(disp_pkt.rd), 32'(exp_disp.rd));
            check_value("disp_pkt_o.is_load", ln, 32'(disp_pkt.is_load),
                        32'(exp_disp.is_load));
        end
    endtask

    // stage contents after the coming rising edge
    task automatic advance_model(input vec_t v);
        if (!v.ctrl.hold_dispatch) begin
            exp_disp.pc      = exp_id.pc;
            exp_disp.inst    = exp_id.inst;
            // rd in bits 11:7, load major opcode 0000011
            exp_disp.rd      = exp_id.inst[11:7];
            exp_disp.is_load = (exp_id.inst[6:0] == 7'b0000011);
            exp_disp_known   = exp_id_known;
        end
        if (!v.ctrl.hold_fetch) begin
            exp_id.pc    = v.pc;
            exp_id.inst  = v.inst;
            exp_id_known = 1'b1;
        end
    endtask

    // main sequence
    initial begin
        clk            = 1'b0;
        reset_i        = 1'b1;
        inst           = '0;
        jump           = 1'b0;
        jump_addr      = '0;
        ex_stall       = 1'b0;
        atom_busy      = 1'b0;
        irq_flush      = 1'b0;
        errors         = 0;
        checks         = 0;
        exp_id         = '0;
        exp_disp       = '0;
        exp_id_known   = 1'b0;
        exp_disp_known = 1'b0;
        load_vectors();
        loaded = 1'b1;
        if (errors == 0) begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            reset_i = 1'b0;
            for (int i = 0; i < vecs.size(); i++) begin
                // inputs change on the falling edge
                apply_inputs(vecs[i]);
                // sample just ahead of the rising edge
                #(CLK_PERIOD / 2 - 1);
                compare_outputs(vecs[i], vec_lines[i]);
                compare_payloads(vecs[i], vec_lines[i]);
                advance_model(vecs[i]);
                @(negedge clk);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        int watch_cycles;
        wait (loaded);
        watch_cycles = vecs.size() + SLACK_CYCLES;
        repeat (watch_cycles) #(CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", watch_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule
